//--- design/hazard_clear.sv
// hazard clear
// registered one-hot mask that retires a pending vreg write mark
`timescale 1ns/1ps

module hazard_clear (
    input  logic                                   clk_i,
    input  logic                                   async_rst_ni,
    input  logic                                   clr_i,
    input  logic [vregpack_pkg::VADDR_W-1:0]       clr_addr_i,
    output logic [(1<<vregpack_pkg::VADDR_W)-1:0]  clear_mask_o
);

    logic [(1<<vregpack_pkg::VADDR_W)-1:0] mask_d;

    always_comb begin
        mask_d = '0;
        if (clr_i) begin
            mask_d[clr_addr_i] = 1'b1;
        end
    end

    // one cycle pulse after the retirement edge
    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            clear_mask_o <= '0;
        end else begin
            clear_mask_o <= mask_d;
        end
    end

endmodule

//--- design/pack_buffer.sv
// pack buffer
// shift register for the 64-bit vreg word and its byte enables
`timescale 1ns/1ps

module pack_buffer (
    input  logic                                  clk_i,
    input  logic                                  async_rst_ni,
    input  logic                                  load_i,
    input  vregpack_pkg::pack_op_e                op_i,
    input  logic [vregpack_pkg::RES_W-1:0]        contrib_i,
    input  logic [vregpack_pkg::RES_W/8-1:0]      contrib_be_i,
    output logic [vregpack_pkg::VPORT_W-1:0]      next_data_o,
    output logic [vregpack_pkg::VPORT_W/8-1:0]    next_be_o
);

    localparam int unsigned DW  = vregpack_pkg::VPORT_W;
    localparam int unsigned RW  = vregpack_pkg::RES_W;
    localparam int unsigned NW  = vregpack_pkg::NARROW_W;

    logic [DW-1:0]   data_q;
    logic [DW/8-1:0] be_q;

    // new contribution enters at the top, older bytes move down
    always_comb begin
        if (op_i == vregpack_pkg::PACK_FULL) begin
            next_data_o = {contrib_i, data_q[DW-1:RW]};
            next_be_o   = {contrib_be_i, be_q[DW/8-1:RW/8]};
        end else begin
            next_data_o = {contrib_i[NW-1:0], data_q[DW-1:NW]};   // 16 bits per narrow beat
            next_be_o   = {contrib_be_i[NW/8-1:0], be_q[DW/8-1:NW/8]};
        end
    end

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            data_q <= '0;
            be_q   <= '0;
        end else if (load_i) begin
            data_q <= next_data_o;
            be_q   <= next_be_o;
        end
    end

endmodule

//--- design/pack_stage.sv
// pack stage
// holds one result beat, stalls stores on pending reads, drives the vreg
// write port and retires the beat with its clear and done reports
`timescale 1ns/1ps

module pack_stage (
    input  logic                                   clk_i,
    input  logic                                   async_rst_ni,
    input  logic                                   in_valid_i,
    output logic                                   in_ready_o,
    input  vregpack_pkg::pack_req_t                in_req_i,
    input  logic [(1<<vregpack_pkg::VADDR_W)-1:0]  pending_vreg_reads_i,
    input  logic                                   wr_ready_i,
    input  logic [vregpack_pkg::VPORT_W-1:0]       buf_data_i,
    input  logic [vregpack_pkg::VPORT_W/8-1:0]     buf_be_i,
    output vregpack_pkg::pack_op_e                 stage_op_o,
    output logic [vregpack_pkg::RES_W-1:0]         stage_data_o,
    output logic [vregpack_pkg::RES_W/8-1:0]       stage_mask_o,
    output logic                                   load_o,
    output logic                                   wr_valid_o,
    output vregpack_pkg::vreg_wr_t                 wr_o,
    output logic                                   clr_o,
    output logic [vregpack_pkg::VADDR_W-1:0]       clr_addr_o,
    output logic                                   done_valid_o,
    output logic [vregpack_pkg::INSTR_ID_W-1:0]    done_id_o
);

    logic                    stage_valid_q;
    vregpack_pkg::pack_req_t stage_q;
    logic                    run_q;   // input opens one cycle after reset
    logic                    stall;
    logic                    retire;
    logic                    accept;

    // a store must wait until the destination has no pending read
    assign stall  = stage_q.store & pending_vreg_reads_i[stage_q.vaddr];
    assign retire = stage_valid_q & ~stall & (~stage_q.store | wr_ready_i);

    assign in_ready_o = run_q & (~stage_valid_q | retire);
    assign accept     = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i or negedge async_rst_ni) begin
        if (!async_rst_ni) begin
            run_q         <= 1'b0;
            stage_valid_q <= 1'b0;
        end else begin
            run_q <= 1'b1;
            if (in_ready_o) begin
                stage_valid_q <= in_valid_i;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (accept) begin
            stage_q <= in_req_i;
        end
    end

    assign stage_op_o   = stage_q.op;
    assign stage_data_o = stage_q.data;
    assign stage_mask_o = stage_q.mask;
    assign load_o       = retire; // buffer shifts as the beat leaves

    // write carries the buffer including this beat
    assign wr_valid_o = stage_valid_q & stage_q.store & ~stall;
    assign wr_o       = '{addr: stage_q.vaddr, be: buf_be_i, data: buf_data_i};

    assign clr_o      = retire & stage_q.pend_clr;
    assign clr_addr_o = stage_q.vaddr;

    assign done_valid_o = retire & stage_q.instr_done;
    assign done_id_o    = stage_q.instr_id;

endmodule

//--- design/result_narrower.sv
// result narrower
// turns two 16-bit elements into bytes with optional signed or unsigned
// saturation, full results pass through unchanged
`timescale 1ns/1ps

module result_narrower (
    input  vregpack_pkg::pack_op_e                op_i,
    input  logic [vregpack_pkg::RES_W-1:0]        data_i,
    input  logic [vregpack_pkg::RES_W/8-1:0]      mask_i,
    output logic [vregpack_pkg::RES_W-1:0]        contrib_o,
    output logic [vregpack_pkg::RES_W/8-1:0]      contrib_be_o
);

    localparam int unsigned ELEM_W   = vregpack_pkg::RES_W / 2;
    localparam int unsigned ELEM_CNT = vregpack_pkg::RES_W / ELEM_W;

    logic [vregpack_pkg::NARROW_W-1:0] narrowed; // both bytes side by side

    for (genvar e = 0; e < ELEM_CNT; e++) begin : g_elem
        logic [7:0] lo_byte;
        logic [7:0] hi_byte;
        logic [7:0] nb;

        assign lo_byte = data_i[e*ELEM_W +: 8];
        assign hi_byte = data_i[e*ELEM_W+8 +: 8];

        always_comb begin
            nb = lo_byte; // plain narrowing keeps the low byte
            unique case (op_i)
                vregpack_pkg::PACK_NARROW_SSAT: begin
                    // out of range if the high byte is not a sign extension
                    if (hi_byte != {8{lo_byte[7]}}) begin
                        nb = {hi_byte[7], {7{~hi_byte[7]}}}; // 0x7F or 0x80
                    end
                end
                vregpack_pkg::PACK_NARROW_USAT: begin
                    if (hi_byte != 8'h00) begin
                        nb = 8'hFF;
                    end
                end
                default: ;
            endcase
        end

        assign narrowed[e*8 +: 8] = nb;
    end

    always_comb begin
        contrib_o    = data_i;
        contrib_be_o = mask_i;
        if (op_i != vregpack_pkg::PACK_FULL) begin
            contrib_o    = '0;
            contrib_be_o = '0;
            contrib_o[vregpack_pkg::NARROW_W-1:0] = narrowed;
            for (int e = 0; e < ELEM_CNT; e++) begin
                contrib_be_o[e] = mask_i[2*e]; // first byte enable of each element
            end
        end
    end

endmodule

//--- design/vregpack_pkg.sv
// vector register result packer package
// widths, the packing opcodes and the structs shared by all packer blocks
package vregpack_pkg;

    localparam int unsigned VPORT_W    = 64; // vreg write port width
    localparam int unsigned RES_W      = 32; // one result beat
    localparam int unsigned NARROW_W   = 16; // bits added by a narrowing beat
    localparam int unsigned VADDR_W    = 5;  // 32 vector registers
    localparam int unsigned INSTR_ID_W = 3;

    // how a beat is shifted into the vreg word
    typedef enum logic [1:0] {
        PACK_FULL        = 2'd0, // whole 32-bit result
        PACK_NARROW      = 2'd1, // low byte of each 16-bit element
        PACK_NARROW_SSAT = 2'd2, // signed saturation
        PACK_NARROW_USAT = 2'd3  // unsigned saturation
    } pack_op_e;

    // one beat from the execution pipeline
    typedef struct packed {
        logic [INSTR_ID_W-1:0] instr_id;
        logic [VADDR_W-1:0]    vaddr;
        pack_op_e              op;
        logic                  store;      // write buffer after this beat
        logic [RES_W-1:0]      data;
        logic [RES_W/8-1:0]    mask;       // byte enables of data
        logic                  pend_clr;   // retire pending write mark
        logic                  instr_done;
    } pack_req_t;

    // vector register file write request
    typedef struct packed {
        logic [VADDR_W-1:0]   addr;
        logic [VPORT_W/8-1:0] be;
        logic [VPORT_W-1:0]   data;
    } vreg_wr_t;

endpackage

//--- design/vregpack_top.sv
// vector register result packer
// packs full and narrowed result beats into 64-bit vreg writes and
// reports pending write clears and finished instructions
`timescale 1ns/1ps

module vregpack_top (
    input  logic                                   clk_i,
    input  logic                                   async_rst_ni,

    input  logic                                   pipe_in_valid_i,
    output logic                                   pipe_in_ready_o,
    input  vregpack_pkg::pack_req_t                pipe_in_req_i,

    output logic                                   vreg_wr_valid_o,
    input  logic                                   vreg_wr_ready_i,
    output vregpack_pkg::vreg_wr_t                 vreg_wr_o,

    input  logic [(1<<vregpack_pkg::VADDR_W)-1:0]  pending_vreg_reads_i,
    output logic [(1<<vregpack_pkg::VADDR_W)-1:0]  clear_pending_vreg_writes_o,

    output logic                                   instr_done_valid_o,
    output logic [vregpack_pkg::INSTR_ID_W-1:0]    instr_done_id_o
);

    vregpack_pkg::pack_op_e                stage_op;
    logic [vregpack_pkg::RES_W-1:0]        stage_data;
    logic [vregpack_pkg::RES_W/8-1:0]      stage_mask;
    logic [vregpack_pkg::RES_W-1:0]        contrib;
    logic [vregpack_pkg::RES_W/8-1:0]      contrib_be;
    logic                                  load;
    logic [vregpack_pkg::VPORT_W-1:0]      buf_data;
    logic [vregpack_pkg::VPORT_W/8-1:0]    buf_be;
    logic                                  clr;
    logic [vregpack_pkg::VADDR_W-1:0]      clr_addr;

    pack_stage u_stage (
        .clk_i                (clk_i),
        .async_rst_ni         (async_rst_ni),
        .in_valid_i           (pipe_in_valid_i),
        .in_ready_o           (pipe_in_ready_o),
        .in_req_i             (pipe_in_req_i),
        .pending_vreg_reads_i (pending_vreg_reads_i),
        .wr_ready_i           (vreg_wr_ready_i),
        .buf_data_i           (buf_data),
        .buf_be_i             (buf_be),
        .stage_op_o           (stage_op),
        .stage_data_o         (stage_data),
        .stage_mask_o         (stage_mask),
        .load_o               (load),
        .wr_valid_o           (vreg_wr_valid_o),
        .wr_o                 (vreg_wr_o),
        .clr_o                (clr),
        .clr_addr_o           (clr_addr),
        .done_valid_o         (instr_done_valid_o),
        .done_id_o            (instr_done_id_o)
    );

    result_narrower u_narrower (
        .op_i         (stage_op),
        .data_i       (stage_data),
        .mask_i       (stage_mask),
        .contrib_o    (contrib),
        .contrib_be_o (contrib_be)
    );

    pack_buffer u_buffer (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .load_i       (load),
        .op_i         (stage_op),
        .contrib_i    (contrib),
        .contrib_be_i (contrib_be),
        .next_data_o  (buf_data),
        .next_be_o    (buf_be)
    );

    hazard_clear u_hazard_clear (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .clr_i        (clr),
        .clr_addr_i   (clr_addr),
        .clear_mask_o (clear_pending_vreg_writes_o)
    );

endmodule

//--- sim/vregpack_checker.sv
// packer scoreboard
// compares vreg writes, clear masks and done pulses against queued expectations
`timescale 1ns/1ps

module vregpack_checker (
    input logic                                   clk_i,
    input logic                                   async_rst_ni,
    input logic                                   in_ready_i,
    input logic                                   wr_valid_i,
    input logic                                   wr_ready_i,
    input vregpack_pkg::vreg_wr_t                 wr_i,
    input logic [(1<<vregpack_pkg::VADDR_W)-1:0]  pending_i,
    input logic [(1<<vregpack_pkg::VADDR_W)-1:0]  clear_mask_i,
    input logic                                   done_valid_i,
    input logic [vregpack_pkg::INSTR_ID_W-1:0]    done_id_i
);

    string                                   wr_names[$];
    vregpack_pkg::vreg_wr_t                  wr_exp[$];
    string                                   clr_names[$];
    logic [vregpack_pkg::VADDR_W-1:0]        clr_exp[$];
    string                                   done_names[$];
    logic [vregpack_pkg::INSTR_ID_W-1:0]     done_exp[$];
    int err_cnt = 0;
    int wr_cnt = 0;
    int clr_cnt = 0;
    int done_cnt = 0;

    task automatic expect_write(input string name, input vregpack_pkg::vreg_wr_t exp);
        wr_names.push_back(name);
        wr_exp.push_back(exp);
    endtask

    task automatic expect_clear(input string name, input logic [vregpack_pkg::VADDR_W-1:0] addr);
        clr_names.push_back(name);
        clr_exp.push_back(addr);
    endtask

    task automatic expect_done(input string name, input logic [vregpack_pkg::INSTR_ID_W-1:0] id);
        done_names.push_back(name);
        done_exp.push_back(id);
    endtask

    function automatic int error_count();
        return err_cnt;
    endfunction

    function automatic int outstanding();
        return wr_exp.size() + clr_exp.size() + done_exp.size();
    endfunction

    // everything is stable at the falling edge
    always @(negedge clk_i) begin : compare
        string                                name;
        string                                exp_s;
        string                                act_s;
        vregpack_pkg::vreg_wr_t               exp;
        logic [(1<<vregpack_pkg::VADDR_W)-1:0] exp_mask;
        if (async_rst_ni) begin
            if (wr_valid_i && wr_ready_i) begin
                if (wr_exp.size() == 0) begin
                    $display("unexpected write to vreg %0d with no store row waiting", wr_i.addr);
                    err_cnt++;
                end else begin
                    name = wr_names.pop_front();
                    exp  = wr_exp.pop_front();
                    wr_cnt++;
                    if (wr_i !== exp) begin
                        exp_s = $sformatf("addr %0d be %h data %h",
                                          exp.addr, exp.be, exp.data);
                        act_s = $sformatf("addr %0d be %h data %h",
                                          wr_i.addr, wr_i.be, wr_i.data);
                        $display("[ERROR] %s: expected %s, actual %s", name, exp_s, act_s);
                        err_cnt++;
                    end else begin
                        $display("ok %s: vreg %0d be %h data %h", name,
                                 wr_i.addr, wr_i.be, wr_i.data);
                    end
                end
            end
            if (wr_valid_i && pending_i[wr_i.addr]) begin
                $display("write to vreg %0d offered while its read is still pending", wr_i.addr);
                err_cnt++;
            end
            if (wr_valid_i && !wr_ready_i && in_ready_i) begin
                $display("input ready was high while the vreg write was back-pressured");
                err_cnt++;
            end
            if (clear_mask_i != '0) begin
                if (clr_exp.size() == 0) begin
                    $display("unexpected clear mask %h", clear_mask_i);
                    err_cnt++;
                end else begin
                    name     = clr_names.pop_front();
                    exp_mask = '0;
                    exp_mask[clr_exp.pop_front()] = 1'b1;
                    clr_cnt++;
                    if (clear_mask_i !== exp_mask) begin
                        $display("[ERROR] %s: expected clear %h, actual clear %h",
                                 name, exp_mask, clear_mask_i);
                        err_cnt++;
                    end
                end
            end
            if (done_valid_i) begin
                if (done_exp.size() == 0) begin
                    $display("unexpected done pulse for id %0d", done_id_i);
                    err_cnt++;
                end else begin
                    name = done_names.pop_front();
                    done_cnt++;
                    if (done_id_i !== done_exp[0]) begin
                        $display("[ERROR] %s: expected done id %0d, actual done id %0d",
                                 name, done_exp[0], done_id_i);
                        err_cnt++;
                    end
                    void'(done_exp.pop_front());
                end
            end
        end
    end

    task automatic final_report();
        foreach (wr_names[i]) $display("missing vreg write for %s", wr_names[i]);
        foreach (clr_names[i]) $display("missing clear mask for %s", clr_names[i]);
        foreach (done_names[i]) $display("missing done pulse for %s", done_names[i]);
        err_cnt += outstanding();
        $display("checked %0d writes, %0d clears, %0d done pulses, %0d errors",
                 wr_cnt, clr_cnt, done_cnt, err_cnt);
    endtask

endmodule

//--- sim/vregpack_properties.sv
// packer handshake properties
// write port stability, one-hot clear mask and single done pulses
`timescale 1ns/1ps

module vregpack_properties (
    input logic                                   clk_i,
    input logic                                   async_rst_ni,
    input logic                                   in_valid_i,
    input logic                                   wr_valid_i,
    input logic                                   wr_ready_i,
    input vregpack_pkg::vreg_wr_t                 wr_i,
    input logic [(1<<vregpack_pkg::VADDR_W)-1:0]  clear_mask_i,
    input logic                                   done_valid_i,
    input logic [vregpack_pkg::INSTR_ID_W-1:0]    done_id_i
);

    int fail_count = 0; // read by the testbench at the end

    wr_stable: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        wr_valid_i && !wr_ready_i |=> wr_valid_i && $stable(wr_i))
        else begin
            fail_count++;
            $error("vreg write changed while back-pressured");
        end

    clear_onehot: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        $onehot0(clear_mask_i))
        else begin
            fail_count++;
            $error("clear mask has more than one bit set");
        end

    // an idle input cannot produce a second done for the same beat
    done_single: assert property (@(posedge clk_i) disable iff (!async_rst_ni)
        done_valid_i && !in_valid_i |=> !(done_valid_i && done_id_i == $past(done_id_i)))
        else begin
            fail_count++;
            $error("done pulse repeated for id %0d", done_id_i);
        end

endmodule

bind vregpack_top vregpack_properties props0 (
    .clk_i        (clk_i),
    .async_rst_ni (async_rst_ni),
    .in_valid_i   (pipe_in_valid_i),
    .wr_valid_i   (vreg_wr_valid_o),
    .wr_ready_i   (vreg_wr_ready_i),
    .wr_i         (vreg_wr_o),
    .clear_mask_i (clear_pending_vreg_writes_o),
    .done_valid_i (instr_done_valid_o),
    .done_id_i    (instr_done_id_o)
);

//--- sim/vregpack_tb.sv
// testbench for the vreg result packer
// applies a table of beats with random write back-pressure and pending reads
`timescale 1ns/1ps

module vregpack_tb;

    localparam int unsigned NUM_ROWS   = 18;
    localparam int unsigned MAX_CYCLES = NUM_ROWS * 40 + 100;
    localparam int unsigned SEED       = 28565;
    localparam vregpack_pkg::pack_op_e FULL = vregpack_pkg::PACK_FULL;
    localparam vregpack_pkg::pack_op_e NARR = vregpack_pkg::PACK_NARROW;
    localparam vregpack_pkg::pack_op_e SSAT = vregpack_pkg::PACK_NARROW_SSAT;
    localparam vregpack_pkg::pack_op_e USAT = vregpack_pkg::PACK_NARROW_USAT;

    logic                    clk_i;
    logic                    async_rst_ni;
    logic                    in_valid;
    logic                    in_ready;
    vregpack_pkg::pack_req_t in_req;
    logic                    wr_valid;
    logic                    wr_ready;
    vregpack_pkg::vreg_wr_t  wr;
    logic [15:0]             row_pend;  // regs 0..15, used by the table
    logic [15:0]             rand_pend; // regs 16..31, random noise
    logic [31:0]             clear_mask;
    logic                    done_valid;
    logic [2:0]              done_id;
    int unsigned             cycles;

    string                   names[NUM_ROWS];
    vregpack_pkg::pack_req_t reqs[NUM_ROWS];
    int                      holds[NUM_ROWS];
    vregpack_pkg::vreg_wr_t  exps[NUM_ROWS];
    int                      n_rows;

    vregpack_top dut0 (
        .clk_i                       (clk_i),
        .async_rst_ni                (async_rst_ni),
        .pipe_in_valid_i             (in_valid),
        .pipe_in_ready_o             (in_ready),
        .pipe_in_req_i               (in_req),
        .vreg_wr_valid_o             (wr_valid),
        .vreg_wr_ready_i             (wr_ready),
        .vreg_wr_o                   (wr),
        .pending_vreg_reads_i        ({rand_pend, row_pend}),
        .clear_pending_vreg_writes_o (clear_mask),
        .instr_done_valid_o          (done_valid),
        .instr_done_id_o             (done_id)
    );

    vregpack_checker chk0 (
        .clk_i        (clk_i),
        .async_rst_ni (async_rst_ni),
        .in_ready_i   (in_ready),
        .wr_valid_i   (wr_valid),
        .wr_ready_i   (wr_ready),
        .wr_i         (wr),
        .pending_i    ({rand_pend, row_pend}),
        .clear_mask_i (clear_mask),
        .done_valid_i (done_valid),
        .done_id_i    (done_id)
    );

    always #4 clk_i = ~clk_i;

    // flags are {store, pend_clr, instr_done}, expected addr is the row vaddr
    task automatic add_row(input string name, input int id, input int vaddr,
                           input vregpack_pkg::pack_op_e op, input logic [2:0] flags,
                           input logic [31:0] data, input logic [3:0] mask, input int hold,
                           input logic [7:0] be, input logic [63:0] wdata);
        vregpack_pkg::pack_req_t req;
        req.instr_id   = 3'(id);
        req.vaddr      = 5'(vaddr);
        req.op         = op;
        req.store      = flags[2];
        req.data       = data;
        req.mask       = mask;
        req.pend_clr   = flags[1];
        req.instr_done = flags[0];
        names[n_rows]  = name;
        reqs[n_rows]   = req;
        holds[n_rows]  = hold;
        exps[n_rows]   = {5'(vaddr), be, wdata};
        n_rows++;
    endtask

    task automatic load_table();
        n_rows = 0;
        // name, id, vaddr, op, flags, data, mask, hold, exp be, exp data
        add_row("full_pair", 1, 3, FULL, 3'b000, 32'h1111_2222, 4'hF, 0, 8'h00, 64'h0);
        add_row("full_pair", 1, 3, FULL, 3'b111, 32'h3333_4444, 4'h3, 0, 8'h3F,
                64'h3333_4444_1111_2222);
        add_row("narrow", 2, 5, NARR, 3'b000, 32'h0012_0034, 4'hF, 0, 8'h00, 64'h0);
        add_row("narrow", 2, 5, NARR, 3'b000, 32'h7F56_0178, 4'hF, 0, 8'h00, 64'h0);
        add_row("narrow", 2, 5, NARR, 3'b000, 32'hFF9A_00BC, 4'h1, 0, 8'h00, 64'h0);
        add_row("narrow", 2, 5, NARR, 3'b101, 32'h00DE_12F0, 4'hF, 0, 8'hDF,
                64'hDEF0_9ABC_5678_1234);
        add_row("narrow_ssat", 3, 6, SSAT, 3'b000, 32'h0005_FFFB, 4'hF, 0, 8'h00, 64'h0);
        add_row("narrow_ssat", 3, 6, SSAT, 3'b000, 32'h8000_7FFF, 4'hF, 0, 8'h00, 64'h0);
        add_row("narrow_ssat", 3, 6, SSAT, 3'b000, 32'h0080_FF7F, 4'hF, 0, 8'h00, 64'h0);
        add_row("narrow_ssat", 3, 6, SSAT, 3'b110, 32'h007F_FF80, 4'hF, 0, 8'hFF,
                64'h7F80_7F80_807F_05FB);
        add_row("narrow_usat", 4, 7, USAT, 3'b000, 32'h0100_0042, 4'hF, 0, 8'h00, 64'h0);
        add_row("narrow_usat", 4, 7, USAT, 3'b000, 32'hFFFF_0080, 4'h4, 0, 8'h00, 64'h0);
        add_row("narrow_usat", 4, 7, USAT, 3'b000, 32'h0033_8001, 4'hF, 0, 8'h00, 64'h0);
        add_row("narrow_usat", 4, 7, USAT, 3'b100, 32'h0012_0034, 4'hF, 0, 8'hFB,
                64'h1234_33FF_FF80_FF42);
        add_row("read_stall", 5, 9, FULL, 3'b000, 32'hCAFE_0001, 4'hF, 0, 8'h00, 64'h0);
        add_row("read_stall", 5, 9, FULL, 3'b111, 32'hBEEF_0002, 4'hC, 6, 8'hCF,
                64'hBEEF_0002_CAFE_0001);
        add_row("backpressure", 6, 12, FULL, 3'b001, 32'h0BAD_F00D, 4'hF, 0, 8'h00, 64'h0);
        // last beat finishes with the input idle
        add_row("backpressure", 6, 12, FULL, 3'b111, 32'hDEAD_BEEF, 4'h9, 0, 8'h9F,
                64'hDEAD_BEEF_0BAD_F00D);
    endtask

    // called 1 ns after a rising edge, returns 1 ns after the accepting edge
    task automatic apply_row(input int r);
        in_req   = reqs[r];
        in_valid = 1'b1;
        if (reqs[r].store) chk0.expect_write(names[r], exps[r]);
        if (reqs[r].pend_clr) chk0.expect_clear(names[r], reqs[r].vaddr);
        if (reqs[r].instr_done) chk0.expect_done(names[r], reqs[r].instr_id);
        @(negedge clk_i);
        while (!in_ready) @(negedge clk_i);
        @(posedge clk_i);
        #1;
        in_valid = 1'b0;
        if (holds[r] > 0) begin
            row_pend[reqs[r].vaddr[3:0]] = 1'b1; // destination read still in flight
            repeat (holds[r]) @(posedge clk_i);
            #1;
            row_pend[reqs[r].vaddr[3:0]] = 1'b0;
        end
    endtask

    initial begin : backpressure
        void'($urandom(SEED));
        forever begin
            @(posedge clk_i);
            #1;
            wr_ready  = ($urandom % 5) < 3;
            rand_pend = 16'($urandom);
        end
    end

    always @(posedge clk_i) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    initial begin
        clk_i        = 1'b0;
        async_rst_ni = 1'b0;
        in_valid     = 1'b0;
        in_req       = '0;
        wr_ready     = 1'b0;
        row_pend     = '0;
        rand_pend    = '0;
        cycles       = 0;
        load_table();
        repeat (5) @(posedge clk_i);
        #1;
        async_rst_ni = 1'b1;
        for (int r = 0; r < n_rows; r++) begin
            apply_row(r);
        end
        while (chk0.outstanding() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i); // catch late extra pulses
        chk0.final_report();
        if (chk0.error_count() + dut0.props0.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

//--- src.f
design/vregpack_pkg.sv
design/result_narrower.sv
design/pack_buffer.sv
design/pack_stage.sv
design/hazard_clear.sv
design/vregpack_top.sv
sim/vregpack_properties.sv
sim/vregpack_checker.sv
sim/vregpack_tb.sv
